/* FragmentTestUnit.f */
RasterTypesPkg.sv
RegisterMapPkg.sv
FragConfigDecode.sv
TestFunc.sv
DepthBuffer.sv
FragmentTestExec.sv
FragmentResult.sv
FragmentTestUnit.sv
FragmentTestUnit_chk.sv
tb_FragmentTestUnit.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the fragment test unit testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --timescale 1ns/1ns --top-module tb_FragmentTestUnit \
    -f FragmentTestUnit.f -o Vtb_FragmentTestUnit \
    && ./obj_dir/Vtb_FragmentTestUnit +verilator+error+limit+100 | tee sim.log \
    || { echo "Build or run of the simulation failed"; exit 1; }
grep -q "^sim passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* fragment_trace.txt */
# Records: R addr data | F addr depth alpha color | E addr color | T name
# All values hex, E lines give the expected pixels of a test in output order
R 2 00008000
F 10 1000 ff 1111
F 11 1000 ff 2222
T clear_drop
F 20 1234 00 f800
F 21 0000 ff 07e0
F 22 ffff 40 001f
E 20 f800
E 21 07e0
E 22 001f
T pass_through
# Alpha reference 80, all eight functions, color is function and alpha
R 0 00008008
F 30 0100 7f 007f
F 30 0100 80 0080
F 30 0100 81 0081
E 30 007f
E 30 0080
E 30 0081
R 0 00008009
F 30 0100 7f 017f
F 30 0100 80 0180
F 30 0100 81 0181
R 0 0000800a
F 30 0100 7f 027f
F 30 0100 80 0280
F 30 0100 81 0281
E 30 027f
R 0 0000800b
F 30 0100 7f 037f
F 30 0100 80 0380
F 30 0100 81 0381
E 30 0380
R 0 0000800c
F 30 0100 7f 047f
F 30 0100 80 0480
F 30 0100 81 0481
E 30 047f
E 30 0480
R 0 0000800d
F 30 0100 7f 057f
F 30 0100 80 0580
F 30 0100 81 0581
E 30 0581
R 0 0000800e
F 30 0100 7f 067f
F 30 0100 80 0680
F 30 0100 81 0681
E 30 067f
E 30 0681
R 0 0000800f
F 30 0100 7f 077f
F 30 0100 80 0780
F 30 0100 81 0781
E 30 0780
E 30 0781
T alpha_funcs
# Depth LESS with write-back, back to back to one address
R 0 00000000
R 1 0000001a
F 40 7000 ff a001
F 40 7500 ff a002
F 40 6000 ff a003
F 40 6000 ff a004
E 40 a001
E 40 a003
# Fresh clear for the mask test
R 2 00008000
T depth_less
# Depth mask off, buffer stays at 8000
R 1 0000000a
F 40 7000 ff b001
F 40 7500 ff b002
F 40 6000 ff b003
F 40 6000 ff b004
E 40 b001
E 40 b002
E 40 b003
E 40 b004
T mask_off
# Alpha GEQUAL 80 with depth GREATER
R 0 0000800f
R 1 0000001d
F 50 9000 7f c001
F 50 8800 80 c002
F 50 8400 ff c003
F 50 8900 81 c004
# Probes, 8900 fails and 8950 passes only with 8900 stored
F 50 8900 ff c005
F 50 8950 ff c006
E 50 c002
E 50 c004
E 50 c006
T combined

/* tb_FragmentTestUnit.sv */
// Trace-driven testbench with clock, stimulus tasks, pixel monitor, compare tasks and timeout
`timescale 1ns/1ns
`default_nettype none

module tb_FragmentTestUnit
    import RasterTypesPkg::*;
    import RegisterMapPkg::*;
();

    // Cycle budget per trace line and per clear
    localparam int CyclesPerLine = 4;
    localparam int CyclesPerClear = 300;
    localparam int ResetCycles = 10;
    // Pipeline depth plus margin
    localparam int DrainCycles = 5;
    localparam string TraceFile = "fragment_trace.txt";

    logic     aclk;
    logic     rst;
    logic     regWrite;
    tRegAddr  regAddr;
    tRegData  regData;
    logic     fragValid;
    tFragAddr fragAddr;
    tDepth    fragDepth;
    tAlpha    fragAlpha;
    tColor    fragColor;
    logic     pixelValid;
    tFragAddr pixelAddr;
    tColor    pixelColor;
    logic     clearBusy;

    // Pixels seen and pixels expected, never trimmed
    tFragAddr gotAddr [$];
    tColor    gotColor [$];
    tFragAddr expAddr [$];
    tColor    expColor [$];
    // First entry of the current test in each queue
    int       gotBase = 0;
    int       expBase = 0;

    int cycleCount = 0;
    int cycleLimit = 100000;
    int testCount = 0;
    int checkCount = 0;
    int errorCount = 0;

    FragmentTestUnit i_dut (
        .aclk      (aclk),
        .rst       (rst),
        .regWrite  (regWrite),
        .regAddr   (regAddr),
        .regData   (regData),
        .fragValid (fragValid),
        .fragAddr  (fragAddr),
        .fragDepth (fragDepth),
        .fragAlpha (fragAlpha),
        .fragColor (fragColor),
        .pixelValid(pixelValid),
        .pixelAddr (pixelAddr),
        .pixelColor(pixelColor),
        .clearBusy (clearBusy)
    );

    // 20 ns clock
    initial
    begin
        aclk = 1'b0;
        forever
            #10 aclk = ~aclk;
    end

    // Pixel monitor, registered outputs sampled at the edge
    always @(posedge aclk)
    begin
        if (!rst && pixelValid)
        begin
            gotAddr.push_back(pixelAddr);
            gotColor.push_back(pixelColor);
        end
    end

    // Ends a run that outlives the trace budget
    initial
    begin
        while (cycleCount < cycleLimit)
        begin
            @(posedge aclk);
            cycleCount++;
        end
        $display("Timeout, the trace did not finish within %0d cycles", cycleLimit);
        $display("sim failed");
        $finish;
    end

    // Idle cycles, nothing driven
    task automatic idleCycles(input int count);
        repeat (count)
        begin
            @(posedge aclk);
            #2;
            regWrite  = 1'b0;
            fragValid = 1'b0;
        end
    endtask

    // Drain first, then one write, then one idle cycle so clearBusy is up
    task automatic writeReg(input tRegAddr addr, input tRegData data);
        idleCycles(DrainCycles - 1);
        @(posedge aclk);
        #2;
        fragValid = 1'b0;
        regWrite  = 1'b1;
        regAddr   = addr;
        regData   = data;
        idleCycles(1);
    endtask

    task automatic sendFragment(input tFragAddr addr, input tDepth depth,
                                input tAlpha alpha, input tColor color);
        @(posedge aclk);
        #2;
        regWrite  = 1'b0;
        fragValid = 1'b1;
        fragAddr  = addr;
        fragDepth = depth;
        fragAlpha = alpha;
        fragColor = color;
    endtask

    task automatic checkAddr(input string name, input tFragAddr got, input tFragAddr exp);
        checkCount++;
        if (got !== exp)
        begin
            errorCount++;
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic checkColor(input string name, input tColor got, input tColor exp);
        checkCount++;
        if (got !== exp)
        begin
            errorCount++;
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic reportBadLine(input string line);
        errorCount++;
        $display("Trace line could not be read: %s", line);
    endtask

    // Drain, wait out a clear, compare this test's pixels in order
    task automatic finishTest(input string name);
        int gotCount;
        int expCount;
        int errorsBefore;
        int i;
        idleCycles(DrainCycles);
        while (clearBusy)
            idleCycles(1);
        errorsBefore = errorCount;
        gotCount = gotAddr.size() - gotBase;
        expCount = expAddr.size() - expBase;
        if (gotCount < expCount)
        begin
            errorCount++;
            $display("Test %s is missing %0d pixels", name, expCount - gotCount);
        end
        else if (gotCount > expCount)
        begin
            errorCount++;
            $display("Test %s produced %0d extra pixels", name, gotCount - expCount);
        end
        for (i = 0; i < gotCount && i < expCount; i++)
        begin
            checkAddr("pixelAddr", gotAddr[gotBase + i], expAddr[expBase + i]);
            checkColor("pixelColor", gotColor[gotBase + i], expColor[expBase + i]);
        end
        testCount++;
        $display("Test %0d %s: %0d pixels, %0d errors", testCount, name, gotCount,
                 errorCount - errorsBefore);
        gotBase = gotAddr.size();
        expBase = expAddr.size();
    endtask

    initial
    begin
        int       fd;
        int       lineCount;
        int       clearCount;
        int       fields;
        int       assertFails;
        string    line;
        string    testName;
        tRegAddr  rAddr;
        tRegData  rData;
        tFragAddr fAddr;
        tDepth    fDepth;
        tAlpha    fAlpha;
        tColor    fColor;

        rst       = 1'b1;
        regWrite  = 1'b0;
        regAddr   = '0;
        regData   = '0;
        fragValid = 1'b0;
        fragAddr  = '0;
        fragDepth = '0;
        fragAlpha = '0;
        fragColor = '0;

        // First pass sizes the run limit
        lineCount = 0;
        clearCount = 0;
        fd = $fopen(TraceFile, "r");
        if (fd == 0)
        begin
            errorCount++;
            $display("Cannot open the trace file %s", TraceFile);
        end
        else
        begin
            while ($fgets(line, fd) != 0)
            begin
                lineCount++;
                if (line[0] == "R")
                begin
                    fields = $sscanf(line, "R %h %h", rAddr, rData);
                    if (fields == 2 && rAddr == RegDepthClear)
                        clearCount++;
                end
            end
            $fclose(fd);
            cycleLimit = ResetCycles + lineCount * CyclesPerLine + clearCount * CyclesPerClear;
        end

        repeat (ResetCycles) @(posedge aclk);
        #2;
        rst = 1'b0;

        // Second pass drives the trace
        fd = $fopen(TraceFile, "r");
        if (fd != 0)
        begin
            while ($fgets(line, fd) != 0)
            begin
                case (line[0])
                    "R":
                    begin
                        fields = $sscanf(line, "R %h %h", rAddr, rData);
                        if (fields == 2)
                            writeReg(rAddr, rData);
                        else
                            reportBadLine(line);
                    end
                    "F":
                    begin
                        fields = $sscanf(line, "F %h %h %h %h", fAddr, fDepth, fAlpha, fColor);
                        if (fields == 4)
                            sendFragment(fAddr, fDepth, fAlpha, fColor);
                        else
                            reportBadLine(line);
                    end
                    "E":
                    begin
                        fields = $sscanf(line, "E %h %h", fAddr, fColor);
                        if (fields == 2)
                        begin
                            expAddr.push_back(fAddr);
                            expColor.push_back(fColor);
                        end
                        else
                            reportBadLine(line);
                    end
                    "T":
                    begin
                        fields = $sscanf(line, "T %s", testName);
                        if (fields == 1)
                            finishTest(testName);
                        else
                            reportBadLine(line);
                    end
                    // Comments and blank lines
                    default:
                    begin
                    end
                endcase
            end
            $fclose(fd);
        end

        idleCycles(DrainCycles);
        assertFails = i_dut.u_chk.resetFails + i_dut.u_chk.startFails
                    + i_dut.u_chk.lengthFails + i_dut.u_chk.writeFails;
        $display("Tests %0d, checks %0d, errors %0d, assertion failures %0d",
                 testCount, checkCount, errorCount, assertFails);
        if (errorCount == 0 && assertFails == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

/* FragmentTestUnit_chk.sv */
// Concurrent assertions on reset, clear length and depth write-back, bound to the top level
`timescale 1ns/1ns
`default_nettype none

module FragmentTestUnitChk
    import RasterTypesPkg::*;
(
    input logic aclk,
    input logic rst,
    input logic pixelValid,
    input logic clearBusy,
    input logic clearStart,
    input logic wrEnable
);

    // Cycles spent in the running clear
    int busyLen;

    // Failure counts, one per assertion
    int resetFails = 0;
    int startFails = 0;
    int lengthFails = 0;
    int writeFails = 0;

    always_ff @(posedge aclk)
    begin
        if (rst || !clearBusy)
            busyLen <= 0;
        else
            busyLen <= busyLen + 1;
    end

    // No pixel in the first three cycles out of reset
    pixelQuietAfterReset: assert property (@(posedge aclk)
        !rst && ($past(rst) || $past(rst, 2) || $past(rst, 3)) |-> !pixelValid)
    else
    begin
        $error("pixelValid high within three cycles after reset");
        resetFails++;
    end

    // Busy on the cycle after the start pulse
    clearFollowsStart: assert property (@(posedge aclk) disable iff (rst)
        clearStart |=> clearBusy)
    else
    begin
        $error("clearBusy did not rise after clearStart");
        startFails++;
    end

    // One cycle per buffer entry
    clearLength: assert property (@(posedge aclk) disable iff (rst)
        $fell(clearBusy) |-> busyLen == DepthEntries)
    else
    begin
        $error("clearBusy lasted %0d cycles", busyLen);
        lengthFails++;
    end

    // Clear owns the memory port
    noWriteDuringClear: assert property (@(posedge aclk) disable iff (rst)
        !(wrEnable && clearBusy))
    else
    begin
        $error("Depth write while clearBusy is high");
        writeFails++;
    end

endmodule

bind FragmentTestUnit FragmentTestUnitChk u_chk (
    .aclk      (aclk),
    .rst       (rst),
    .pixelValid(pixelValid),
    .clearBusy (clearBusy),
    .clearStart(clearStart),
    .wrEnable  (wrEnable)
);

`default_nettype wire

/* FragmentTestUnit.sv */
// Fragment test unit top level with decode, test pipeline, depth buffer and result
`timescale 1ns/1ns
`default_nettype none

module FragmentTestUnit
    import RasterTypesPkg::*;
    import RegisterMapPkg::*;
(
    input  logic     aclk,
    input  logic     rst,
    // Register port
    input  logic     regWrite,
    input  tRegAddr  regAddr,
    input  tRegData  regData,
    // Fragment port
    input  logic     fragValid,
    input  tFragAddr fragAddr,
    input  tDepth    fragDepth,
    input  tAlpha    fragAlpha,
    input  tColor    fragColor,
    // Pixel port
    output logic     pixelValid,
    output tFragAddr pixelAddr,
    output tColor    pixelColor,
    output logic     clearBusy
);

    // Configuration levels
    tTestFunc alphaFunc;
    tAlpha    alphaRef;
    logic     alphaEnable;
    tTestFunc depthFunc;
    logic     depthEnable;
    logic     depthMask;
    tDepth    clearValue;
    logic     clearStart;

    // Buffer read
    tFragAddr bufReadAddr;
    tDepth    bufReadData;

    // Test stage
    logic     testValid;
    tFragAddr testAddr;
    tDepth    testDepth;
    tColor    testColor;
    logic     alphaPass;
    logic     depthPass;

    // Depth write-back
    logic     wrEnable;
    tFragAddr wrAddr;
    tDepth    wrData;

    FragConfigDecode u_decode (
        .aclk       (aclk),
        .rst        (rst),
        .regWrite   (regWrite),
        .regAddr    (regAddr),
        .regData    (regData),
        .alphaFunc  (alphaFunc),
        .alphaRef   (alphaRef),
        .alphaEnable(alphaEnable),
        .depthFunc  (depthFunc),
        .depthEnable(depthEnable),
        .depthMask  (depthMask),
        .clearValue (clearValue),
        .clearStart (clearStart)
    );

    FragmentTestExec u_exec (
        .aclk       (aclk),
        .rst        (rst),
        .fragValid  (fragValid),
        .fragAddr   (fragAddr),
        .fragDepth  (fragDepth),
        .fragAlpha  (fragAlpha),
        .fragColor  (fragColor),
        .clearBusy  (clearBusy),
        .alphaFunc  (alphaFunc),
        .alphaRef   (alphaRef),
        .alphaEnable(alphaEnable),
        .depthFunc  (depthFunc),
        .depthEnable(depthEnable),
        .depthMask  (depthMask),
        .bufReadAddr(bufReadAddr),
        .bufReadData(bufReadData),
        .wrEnable   (wrEnable),
        .wrAddr     (wrAddr),
        .wrData     (wrData),
        .testValid  (testValid),
        .testAddr   (testAddr),
        .testDepth  (testDepth),
        .testColor  (testColor),
        .alphaPass  (alphaPass),
        .depthPass  (depthPass)
    );

    DepthBuffer u_depthBuffer (
        .aclk       (aclk),
        .rst        (rst),
        .readAddr   (bufReadAddr),
        .readData   (bufReadData),
        .writeEnable(wrEnable),
        .writeAddr  (wrAddr),
        .writeData  (wrData),
        .clearStart (clearStart),
        .clearValue (clearValue),
        .clearBusy  (clearBusy)
    );

    FragmentResult u_result (
        .aclk       (aclk),
        .rst        (rst),
        .testValid  (testValid),
        .testAddr   (testAddr),
        .testDepth  (testDepth),
        .testColor  (testColor),
        .alphaPass  (alphaPass),
        .depthPass  (depthPass),
        .depthEnable(depthEnable),
        .depthMask  (depthMask),
        .wrEnable   (wrEnable),
        .wrAddr     (wrAddr),
        .wrData     (wrData),
        .pixelValid (pixelValid),
        .pixelAddr  (pixelAddr),
        .pixelColor (pixelColor)
    );

endmodule

`default_nettype wire

/* FragmentResult.sv */
// Pass decision, depth write-back and registered pixel output
`timescale 1ns/1ns
`default_nettype none

module FragmentResult
    import RasterTypesPkg::*;
(
    input  logic     aclk,
    input  logic     rst,
    // From the test stage
    input  logic     testValid,
    input  tFragAddr testAddr,
    input  tDepth    testDepth,
    input  tColor    testColor,
    input  logic     alphaPass,
    input  logic     depthPass,
    // Depth config
    input  logic     depthEnable,
    input  logic     depthMask,
    // Depth write-back, same cycle
    output logic     wrEnable,
    output tFragAddr wrAddr,
    output tDepth    wrData,
    // Pixel write
    output logic     pixelValid,
    output tFragAddr pixelAddr,
    output tColor    pixelColor
);

    logic fragPass;

    // Both tests must hold
    assign fragPass = testValid & alphaPass & depthPass;

    // Write back only with depth test on and mask set
    assign wrEnable = fragPass & depthEnable & depthMask;
    assign wrAddr   = testAddr;
    assign wrData   = testDepth;

    always_ff @(posedge aclk)
    begin
        if (rst)
            pixelValid <= 1'b0;
        else
            pixelValid <= fragPass;
        // Payload follows the strobe
        pixelAddr  <= testAddr;
        pixelColor <= testColor;
    end

endmodule

`default_nettype wire

/* FragmentTestExec.sv */
// Fragment pipeline with depth read, write forwarding and alpha and depth tests
`timescale 1ns/1ns
`default_nettype none

module FragmentTestExec
    import RasterTypesPkg::*;
    import RegisterMapPkg::*;
(
    input  logic     aclk,
    input  logic     rst,
    // Incoming fragment
    input  logic     fragValid,
    input  tFragAddr fragAddr,
    input  tDepth    fragDepth,
    input  tAlpha    fragAlpha,
    input  tColor    fragColor,
    input  logic     clearBusy,
    // Test configuration
    input  tTestFunc alphaFunc,
    input  tAlpha    alphaRef,
    input  logic     alphaEnable,
    input  tTestFunc depthFunc,
    input  logic     depthEnable,
    input  logic     depthMask,
    // Depth buffer read
    output tFragAddr bufReadAddr,
    input  tDepth    bufReadData,
    // Pending write of the fragment in the result stage
    input  logic     wrEnable,
    input  tFragAddr wrAddr,
    input  tDepth    wrData,
    // Test stage outputs
    output logic     testValid,
    output tFragAddr testAddr,
    output tDepth    testDepth,
    output tColor    testColor,
    output logic     alphaPass,
    output logic     depthPass
);

    // Input stage, issues the buffer read
    logic     inValid;
    tFragAddr inAddr;
    tDepth    inDepth;
    tAlpha    inAlpha;
    tColor    inColor;

    // Read stage, buffer data arrives here
    logic     rdValid;
    tFragAddr rdAddr;
    tDepth    rdDepth;
    tAlpha    rdAlpha;
    tColor    rdColor;

    tDepth    storedDepth;
    logic     forwardHit;

    // Fragments during a clear are dropped
    always_ff @(posedge aclk)
    begin
        if (rst)
            inValid <= 1'b0;
        else
            inValid <= fragValid & ~clearBusy;
        inAddr  <= fragAddr;
        inDepth <= fragDepth;
        inAlpha <= fragAlpha;
        inColor <= fragColor;
    end

    assign bufReadAddr = inAddr;

    always_ff @(posedge aclk)
    begin
        if (rst)
            rdValid <= 1'b0;
        else
            rdValid <= inValid;
        rdAddr  <= inAddr;
        rdDepth <= inDepth;
        rdAlpha <= inAlpha;
        rdColor <= inColor;
    end

    // Older fragment one stage ahead writes on the next edge,
    // the read already missed it
    assign forwardHit  = wrEnable & depthMask & (wrAddr == rdAddr);
    assign storedDepth = forwardHit ? wrData : bufReadData;

    TestFunc #(
        .Width(8)
    ) u_alphaTest (
        .aclk      (aclk),
        .func      (alphaFunc),
        .refVal    (alphaRef),
        .confEnable(alphaEnable),
        .val       (rdAlpha),
        .success   (alphaPass)
    );

    // Fragment depth against stored depth
    TestFunc #(
        .Width(16)
    ) u_depthTest (
        .aclk      (aclk),
        .func      (depthFunc),
        .refVal    (storedDepth),
        .confEnable(depthEnable),
        .val       (rdDepth),
        .success   (depthPass)
    );

    // Delay fields to line up with the test results
    always_ff @(posedge aclk)
    begin
        if (rst)
            testValid <= 1'b0;
        else
            testValid <= rdValid;
        testAddr  <= rdAddr;
        testDepth <= rdDepth;
        testColor <= rdColor;
    end

endmodule

`default_nettype wire

/* DepthBuffer.sv */
// Depth memory with write-first read port and sequential clear FSM
`timescale 1ns/1ns
`default_nettype none

module DepthBuffer
    import RasterTypesPkg::*;
(
    input  logic     aclk,
    input  logic     rst,
    // Read port, data one cycle later
    input  tFragAddr readAddr,
    output tDepth    readData,
    // Fragment write-back
    input  logic     writeEnable,
    input  tFragAddr writeAddr,
    input  tDepth    writeData,
    // Clear control
    input  logic     clearStart,
    input  tDepth    clearValue,
    output logic     clearBusy
);

    typedef enum logic {
        ClearIdle,
        ClearRun
    } tClearState;

    localparam tFragAddr LastEntry = tFragAddr'(DepthEntries - 1);

    tDepth      mem [DepthEntries];
    tClearState clearState;
    tFragAddr   clearAddr;

    // Effective write port
    logic       memWe;
    tFragAddr   memWAddr;
    tDepth      memWData;

    // Clear walk owns the port while running
    always_comb
    begin
        if (clearState == ClearRun)
        begin
            memWe    = 1'b1;
            memWAddr = clearAddr;
            memWData = clearValue;
        end
        else
        begin
            memWe    = writeEnable;
            memWAddr = writeAddr;
            memWData = writeData;
        end
    end

    // Memory and read port, new data wins on collision
    always_ff @(posedge aclk)
    begin
        if (memWe)
            mem[memWAddr] <= memWData;
        if (memWe && (memWAddr == readAddr))
            readData <= memWData;
        else
            readData <= mem[readAddr];
    end

    // Clear FSM, entries 0 to last in order
    always_ff @(posedge aclk)
    begin
        if (rst)
        begin
            clearState <= ClearIdle;
            clearAddr  <= '0;
        end
        else
        begin
            case (clearState)
                ClearIdle:
                begin
                    clearAddr <= '0;
                    if (clearStart)
                        clearState <= ClearRun;
                end
                ClearRun:
                begin
                    clearAddr <= clearAddr + 1'b1;
                    // Last entry written this edge
                    if (clearAddr == LastEntry)
                        clearState <= ClearIdle;
                end
                default:
                    clearState <= ClearIdle;
            endcase
        end
    end

    assign clearBusy = (clearState == ClearRun);

endmodule

`default_nettype wire

/* TestFunc.sv */
// Registered eight-function comparator with enable
`timescale 1ns/1ns
`default_nettype none

module TestFunc
    import RegisterMapPkg::*;
#(
    parameter int Width = 8
)
(
    input  logic             aclk,
    input  tTestFunc         func,
    input  logic [Width-1:0] refVal,
    input  logic             confEnable,
    input  logic [Width-1:0] val,
    output logic             success
);

    logic less;
    logic greater;
    logic equal;
    logic check;

    // Raw relations of val against the reference
    assign less    = val < refVal;
    assign greater = val > refVal;
    assign equal   = val == refVal;

    // Select by function code
    always_comb
    begin
        case (func)
            FuncAlways:   check = 1'b1;
            FuncNever:    check = 1'b0;
            FuncLess:     check = less;
            FuncEqual:    check = equal;
            FuncLequal:   check = less | equal;
            FuncGreater:  check = greater;
            FuncNotequal: check = ~equal;
            FuncGequal:   check = greater | equal;
            // Unknown code passes
            default:      check = 1'b1;
        endcase
    end

    // One cycle latency, disabled test always passes
    always_ff @(posedge aclk)
    begin
        success <= ~confEnable | check;
    end

endmodule

`default_nettype wire

/* FragConfigDecode.sv */
// Register decode into alpha and depth test configuration and clear start pulse
`timescale 1ns/1ns
`default_nettype none

module FragConfigDecode
    import RasterTypesPkg::*;
    import RegisterMapPkg::*;
(
    input  logic     aclk,
    input  logic     rst,
    // Register write port
    input  logic     regWrite,
    input  tRegAddr  regAddr,
    input  tRegData  regData,
    // Alpha test config
    output tTestFunc alphaFunc,
    output tAlpha    alphaRef,
    output logic     alphaEnable,
    // Depth test config
    output tTestFunc depthFunc,
    output logic     depthEnable,
    output logic     depthMask,
    // Buffer clear
    output tDepth    clearValue,
    output logic     clearStart
);

    always_ff @(posedge aclk)
    begin
        if (rst)
        begin
            // Tests off, functions pass everything
            alphaFunc   <= FuncAlways;
            alphaRef    <= '0;
            alphaEnable <= 1'b0;
            depthFunc   <= FuncAlways;
            depthEnable <= 1'b0;
            // Write-back allowed by default
            depthMask   <= 1'b1;
            clearValue  <= '0;
            clearStart  <= 1'b0;
        end
        else
        begin
            // Pulse only, one cycle
            clearStart <= 1'b0;
            if (regWrite)
            begin
                case (regAddr)
                    RegAlphaConf:
                    begin
                        alphaFunc   <= regData[FuncLsb +: $bits(tTestFunc)];
                        alphaEnable <= regData[EnableBit];
                        alphaRef    <= regData[AlphaRefLsb +: $bits(tAlpha)];
                    end
                    RegDepthConf:
                    begin
                        depthFunc   <= regData[FuncLsb +: $bits(tTestFunc)];
                        depthEnable <= regData[EnableBit];
                        depthMask   <= regData[DepthMaskBit];
                    end
                    RegDepthClear:
                    begin
                        clearValue <= regData[ClearValueLsb +: $bits(tDepth)];
                        clearStart <= 1'b1;
                    end
                    // Unknown addresses ignored
                    default:
                    begin
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* RegisterMapPkg.sv */
// Register addresses, field positions and test function codes
`default_nettype none

package RegisterMapPkg;

    // Register port widths
    localparam int RegAddrWidth = 4;
    localparam int RegDataWidth = 32;
    localparam int FuncWidth = 3;

    typedef logic [RegAddrWidth-1:0] tRegAddr;
    typedef logic [RegDataWidth-1:0] tRegData;
    typedef logic [FuncWidth-1:0] tTestFunc;

    // Comparison codes, unknown codes act as always
    localparam tTestFunc FuncAlways = 3'd0;
    localparam tTestFunc FuncNever = 3'd1;
    localparam tTestFunc FuncLess = 3'd2;
    localparam tTestFunc FuncEqual = 3'd3;
    localparam tTestFunc FuncLequal = 3'd4;
    localparam tTestFunc FuncGreater = 3'd5;
    localparam tTestFunc FuncNotequal = 3'd6;
    localparam tTestFunc FuncGequal = 3'd7;

    // Register addresses
    localparam tRegAddr RegAlphaConf = 4'd0;
    localparam tRegAddr RegDepthConf = 4'd1;
    // Write also starts a buffer clear
    localparam tRegAddr RegDepthClear = 4'd2;

    // Field positions, shared by alpha and depth config
    localparam int FuncLsb = 0;
    localparam int EnableBit = 3;
    // Alpha config only
    localparam int AlphaRefLsb = 8;
    // Depth config only
    localparam int DepthMaskBit = 4;
    // Clear register
    localparam int ClearValueLsb = 0;

endpackage

`default_nettype wire

/* RasterTypesPkg.sv */
// Fragment data widths, vector typedefs and depth buffer size
`default_nettype none

package RasterTypesPkg;

    // Field widths of a fragment
    localparam int DepthWidth = 16;
    localparam int AlphaWidth = 8;
    // RGB565 packed color
    localparam int ColorWidth = 16;
    localparam int FragAddrWidth = 8;

    // One entry per buffer address
    localparam int DepthEntries = 1 << FragAddrWidth;

    // Fragment depth, also the stored depth
    typedef logic [DepthWidth-1:0] tDepth;

    // Fragment alpha and alpha reference
    typedef logic [AlphaWidth-1:0] tAlpha;

    // Fragment color, 5 bits red, 6 green, 5 blue
    typedef logic [ColorWidth-1:0] tColor;

    // Depth buffer index
    typedef logic [FragAddrWidth-1:0] tFragAddr;

endpackage

`default_nettype wire
